// File: hdl/accel_defines.svh
`ifndef ACCEL_DEFINES_SVH
`define ACCEL_DEFINES_SVH

// ------------------------------------------------------------
// data path sizes
// ------------------------------------------------------------
`define WORD_W          32      // host pipe and memory word width
`define FIFO_DEPTH      64      // words per host FIFO
`define FIFO_CNT_W      7       // holds 0 to FIFO_DEPTH

// ------------------------------------------------------------
// host block throttle
// ------------------------------------------------------------
`define BLOCK_SIZE      16      // words per host block transfer
`define BUFFER_HEADROOM 4       // margin for count latency

// ------------------------------------------------------------
// DMA and word memory
// ------------------------------------------------------------
`define BLOB_BURST_LEN  8       // words per DMA burst
`define MEM_DEPTH       256     // words in the on-chip memory
`define MEM_ADDR_W      8       // memory word address width

`endif

// File: hdl/accel_pkg.sv
`default_nettype none
`include "accel_defines.svh"

package accel_pkg;

	// host control word, bit 0 is reads_en
	typedef struct packed {
		logic fifo_rst;     // clears both FIFOs and the DMA pointers
		logic writes_en;    // lets DMA move pipe-in words to memory
		logic reads_en;     // lets DMA move memory words to pipe-out
	} ctrl_word_t;

	// ------------------------------------------------------------
	// FIFO and memory port bundles
	// ------------------------------------------------------------
	typedef struct packed {
		logic                   full;
		logic                   empty;
		logic [`FIFO_CNT_W-1:0] count;  // exact fill level
	} fifo_status_t;

	typedef struct packed {
		logic                   en;
		logic [`MEM_ADDR_W-1:0] addr;
		logic [`WORD_W-1:0]     data;
	} mem_wr_t;

	typedef struct packed {
		logic                   en;
		logic [`MEM_ADDR_W-1:0] addr;   // data returns on the next cycle
	} mem_rd_t;

endpackage

`default_nettype wire

// File: hdl/sync_fifo.sv
`timescale 1ns/100ps
`default_nettype none
`include "accel_defines.svh"

module sync_fifo (
	input  wire                     okClk,
	input  wire                     i_rst_n,
	input  wire                     i_clear,    // synchronous flush
	input  wire                     i_wr,
	input  wire [`WORD_W-1:0]       i_wr_data,
	input  wire                     i_rd,       // pops the head word
	output logic [`WORD_W-1:0]      o_rd_data,
	output accel_pkg::fifo_status_t o_status
);

	localparam int ADDR_W = $clog2(`FIFO_DEPTH);
	localparam logic [`FIFO_CNT_W-1:0] FULL_CNT = `FIFO_DEPTH;

	logic [`WORD_W-1:0]     mem [`FIFO_DEPTH];
	logic [ADDR_W-1:0]      wr_ptr;
	logic [ADDR_W-1:0]      rd_ptr;
	logic [`FIFO_CNT_W-1:0] count;
	logic                   full;
	logic                   empty;
	logic                   wr_ok;
	logic                   rd_ok;

	assign full  = (count == FULL_CNT);
	assign empty = (count == '0);
	assign rd_ok = i_rd && !empty;
	assign wr_ok = i_wr && (!full || rd_ok);   // a pop frees the slot on the same edge

	assign o_rd_data = mem[rd_ptr];             // head word shows without a read
	assign o_status  = '{full: full, empty: empty, count: count};

	// ------------------------------------------------------------
	// pointers and fill count
	// ------------------------------------------------------------
	always_ff @(posedge okClk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else if (i_clear) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (wr_ok)
				wr_ptr <= wr_ptr + 1'b1;   // wraps at FIFO_DEPTH
			if (rd_ok)
				rd_ptr <= rd_ptr + 1'b1;
			case ({wr_ok, rd_ok})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge okClk) begin
		if (wr_ok)
			mem[wr_ptr] <= i_wr_data;
	end

	// producers upstream must respect full, consumers must respect empty
	a_no_overflow: assert property (@(posedge okClk) disable iff (!i_rst_n)
		i_wr |-> (!full || i_rd))
		else $error("sync_fifo: write while full");

	a_no_underflow: assert property (@(posedge okClk) disable iff (!i_rst_n)
		i_rd |-> !empty)
		else $error("sync_fifo: read while empty");

endmodule

`default_nettype wire

// File: hdl/host_pipes.sv
`timescale 1ns/100ps
`default_nettype none
`include "accel_defines.svh"

module host_pipes (
	input  wire                     okClk,
	input  wire                     i_rst_n,
	input  wire                     i_clear,
	input  wire                     i_pipe_in_write,
	input  wire [`WORD_W-1:0]       i_pipe_in_data,
	output logic                    o_pipe_in_ready,
	input  wire                     i_pipe_out_read,
	output logic [`WORD_W-1:0]      o_pipe_out_data,
	output logic                    o_pipe_out_ready,
	input  wire                     i_dma_pop,
	output logic [`WORD_W-1:0]      o_in_head,
	output accel_pkg::fifo_status_t o_in_status,
	input  wire                     i_dma_push,
	input  wire [`WORD_W-1:0]       i_dma_push_data,
	output accel_pkg::fifo_status_t o_out_status
);

	// room for one more block plus the count latency margin
	localparam logic [`FIFO_CNT_W-1:0] IN_READY_MAX =
		`FIFO_DEPTH - `BUFFER_HEADROOM - `BLOCK_SIZE;
	localparam logic [`FIFO_CNT_W-1:0] OUT_READY_MIN = `BLOCK_SIZE;

	sync_fifo u_pipe_in_fifo (
		.okClk     (okClk),
		.i_rst_n   (i_rst_n),
		.i_clear   (i_clear),
		.i_wr      (i_pipe_in_write),    // host side
		.i_wr_data (i_pipe_in_data),
		.i_rd      (i_dma_pop),          // DMA side
		.o_rd_data (o_in_head),
		.o_status  (o_in_status)
	);

	sync_fifo u_pipe_out_fifo (
		.okClk     (okClk),
		.i_rst_n   (i_rst_n),
		.i_clear   (i_clear),
		.i_wr      (i_dma_push),         // DMA side
		.i_wr_data (i_dma_push_data),
		.i_rd      (i_pipe_out_read),    // host side
		.o_rd_data (o_pipe_out_data),
		.o_status  (o_out_status)
	);

	// ------------------------------------------------------------
	// block throttle
	// ------------------------------------------------------------
	always_ff @(posedge okClk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_pipe_in_ready  <= 1'b0;
			o_pipe_out_ready <= 1'b0;
		end else begin
			o_pipe_in_ready  <= (o_in_status.count <= IN_READY_MAX);
			o_pipe_out_ready <= (o_out_status.count >= OUT_READY_MIN);  // a full block waits
		end
	end

endmodule

`default_nettype wire

// File: hdl/burst_dma.sv
`timescale 1ns/100ps
`default_nettype none
`include "accel_defines.svh"

module burst_dma (
	input  wire                     okClk,
	input  wire                     i_rst_n,
	input  wire accel_pkg::ctrl_word_t   i_ctrl,
	input  wire accel_pkg::fifo_status_t i_in_status,
	input  wire [`WORD_W-1:0]       i_in_head,
	output logic                    o_pop,
	input  wire accel_pkg::fifo_status_t i_out_status,
	output logic                    o_push,
	output logic [`WORD_W-1:0]      o_push_data,
	output accel_pkg::mem_wr_t      o_mem_wr,
	output accel_pkg::mem_rd_t      o_mem_rd,
	input  wire [`WORD_W-1:0]       i_mem_rd_data,
	output logic                    o_wr_busy,
	output logic                    o_rd_busy
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_WRITE,
		ST_READ
	} state_t;

	localparam int CNT_W = $clog2(`BLOB_BURST_LEN + 1);
	localparam int PTR_W = `MEM_ADDR_W + 1;     // extra bit tells full from empty

	localparam logic [CNT_W-1:0]       BEAT_LAST = `BLOB_BURST_LEN - 1;
	localparam logic [CNT_W-1:0]       BEAT_LEN  = `BLOB_BURST_LEN;
	localparam logic [`FIFO_CNT_W-1:0] IN_MIN    = `BLOB_BURST_LEN;
	localparam logic [`FIFO_CNT_W-1:0] OUT_MAX   = `FIFO_DEPTH - `BLOB_BURST_LEN;
	localparam logic [PTR_W-1:0]       STORE_MIN = `BLOB_BURST_LEN;
	localparam logic [PTR_W-1:0]       STORE_MAX = `MEM_DEPTH - `BLOB_BURST_LEN;

	state_t           state;
	logic [CNT_W-1:0] beat;         // position inside the current burst
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W-1:0] stored;       // words held in memory
	logic             rd_pend;      // read return due this cycle
	logic             start_wr;
	logic             start_rd;
	logic             rd_issue;

	// ------------------------------------------------------------
	// burst start conditions
	// ------------------------------------------------------------
	assign stored   = wr_ptr - rd_ptr;
	assign start_wr = i_ctrl.writes_en &&
		(i_in_status.count >= IN_MIN) && (stored <= STORE_MAX);
	assign start_rd = i_ctrl.reads_en &&
		(stored >= STORE_MIN) && (i_out_status.count <= OUT_MAX);

	// read requests stop one beat early, the last beat only drains
	assign rd_issue = (state == ST_READ) && (beat != BEAT_LEN);

	assign o_pop       = (state == ST_WRITE);
	assign o_mem_wr    = '{en: o_pop, addr: wr_ptr[`MEM_ADDR_W-1:0], data: i_in_head};
	assign o_mem_rd    = '{en: rd_issue, addr: rd_ptr[`MEM_ADDR_W-1:0]};
	assign o_push      = rd_pend;
	assign o_push_data = i_mem_rd_data;      // memory output register holds the word
	assign o_wr_busy   = (state == ST_WRITE);
	assign o_rd_busy   = (state == ST_READ);

	// ------------------------------------------------------------
	// burst FSM and memory pointers
	// ------------------------------------------------------------
	always_ff @(posedge okClk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state   <= ST_IDLE;
			beat    <= '0;
			wr_ptr  <= '0;
			rd_ptr  <= '0;
			rd_pend <= 1'b0;
		end else if (i_ctrl.fifo_rst) begin
			state   <= ST_IDLE;         // abort any burst in flight
			beat    <= '0;
			wr_ptr  <= '0;
			rd_ptr  <= '0;
			rd_pend <= 1'b0;
		end else begin
			rd_pend <= rd_issue;
			if (o_pop)
				wr_ptr <= wr_ptr + 1'b1;
			if (rd_issue)
				rd_ptr <= rd_ptr + 1'b1;

			case (state)
				ST_IDLE: begin
					beat <= '0;
					if (start_wr)
						state <= ST_WRITE;  // write burst wins a tie
					else if (start_rd)
						state <= ST_READ;
				end
				ST_WRITE: begin
					beat <= beat + 1'b1;
					if (beat == BEAT_LAST)
						state <= ST_IDLE;
				end
				ST_READ: begin
					beat <= beat + 1'b1;
					if (beat == BEAT_LEN)
						state <= ST_IDLE;   // last return pushed this cycle
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// a read return must never spill into a following write burst
	a_one_kind: assert property (@(posedge okClk) disable iff (!i_rst_n)
		!(o_pop && o_push))
		else $error("burst_dma: pop and push in the same cycle");

	// space was checked at burst start, host pops only add room
	a_push_space: assert property (@(posedge okClk) disable iff (!i_rst_n)
		o_push |-> !i_out_status.full)
		else $error("burst_dma: push into a full pipe-out FIFO");

endmodule

`default_nettype wire

// File: hdl/blob_mem.sv
`timescale 1ns/100ps
`default_nettype none
`include "accel_defines.svh"

module blob_mem (
	input  wire                 okClk,
	input  wire accel_pkg::mem_wr_t i_wr,
	input  wire accel_pkg::mem_rd_t i_rd,
	output logic [`WORD_W-1:0]  o_rd_data
);

	logic [`WORD_W-1:0] mem [`MEM_DEPTH];

	// ------------------------------------------------------------
	// write port
	// ------------------------------------------------------------
	always_ff @(posedge okClk) begin
		if (i_wr.en)
			mem[i_wr.addr] <= i_wr.data;
	end

	// ------------------------------------------------------------
	// read port, one cycle of latency
	// ------------------------------------------------------------
	always_ff @(posedge okClk) begin
		if (i_rd.en)
			o_rd_data <= mem[i_rd.addr];   // holds the last word between requests
	end

endmodule

`default_nettype wire

// File: hdl/accel_top.sv
`timescale 1ns/100ps
`default_nettype none
`include "accel_defines.svh"

module accel_top (
	input  wire                 okClk,
	input  wire                 i_rst_n,
	input  wire accel_pkg::ctrl_word_t i_ctrl,
	input  wire                 i_pipe_in_write,
	input  wire [`WORD_W-1:0]   i_pipe_in_data,
	output logic                o_pipe_in_ready,
	input  wire                 i_pipe_out_read,
	output logic [`WORD_W-1:0]  o_pipe_out_data,
	output logic                o_pipe_out_ready,
	output logic [7:0]          o_led
);

	accel_pkg::fifo_status_t in_status;
	accel_pkg::fifo_status_t out_status;
	accel_pkg::mem_wr_t      mem_wr;
	accel_pkg::mem_rd_t      mem_rd;
	logic [`WORD_W-1:0]      in_head;
	logic [`WORD_W-1:0]      push_data;
	logic [`WORD_W-1:0]      mem_rd_data;
	logic                    dma_pop;
	logic                    dma_push;
	logic                    wr_busy;
	logic                    rd_busy;

	// LEDs are active low
	assign o_led = ~{in_status.full, in_status.empty, out_status.full, out_status.empty,
		wr_busy, i_ctrl.writes_en, i_ctrl.reads_en, rd_busy};

	// ------------------------------------------------------------
	// host FIFOs, DMA and word memory
	// ------------------------------------------------------------
	host_pipes u_host_pipes (
		.okClk            (okClk),
		.i_rst_n          (i_rst_n),
		.i_clear          (i_ctrl.fifo_rst),
		.i_pipe_in_write  (i_pipe_in_write),
		.i_pipe_in_data   (i_pipe_in_data),
		.o_pipe_in_ready  (o_pipe_in_ready),
		.i_pipe_out_read  (i_pipe_out_read),
		.o_pipe_out_data  (o_pipe_out_data),
		.o_pipe_out_ready (o_pipe_out_ready),
		.i_dma_pop        (dma_pop),
		.o_in_head        (in_head),
		.o_in_status      (in_status),
		.i_dma_push       (dma_push),
		.i_dma_push_data  (push_data),
		.o_out_status     (out_status)
	);

	burst_dma u_burst_dma (
		.okClk         (okClk),
		.i_rst_n       (i_rst_n),
		.i_ctrl        (i_ctrl),
		.i_in_status   (in_status),
		.i_in_head     (in_head),
		.o_pop         (dma_pop),
		.i_out_status  (out_status),
		.o_push        (dma_push),
		.o_push_data   (push_data),
		.o_mem_wr      (mem_wr),
		.o_mem_rd      (mem_rd),
		.i_mem_rd_data (mem_rd_data),
		.o_wr_busy     (wr_busy),
		.o_rd_busy     (rd_busy)
	);

	blob_mem u_blob_mem (
		.okClk     (okClk),
		.i_wr      (mem_wr),
		.i_rd      (mem_rd),
		.o_rd_data (mem_rd_data)
	);

endmodule

`default_nettype wire

// File: test/tb_accel_top.sv
`timescale 1ns/100ps
`default_nettype none
`include "accel_defines.svh"

module tb_accel_top;

	localparam int TIMEOUT_CYCLES = 5000;   // about ten times what the five tests take
	localparam int LED_OUT_EMPTY  = 4;
	localparam int LED_IN_EMPTY   = 6;
	localparam int LED_WR_BUSY    = 3;
	localparam int LED_RD_BUSY    = 0;
	localparam int SEL_IN_READY   = 8;      // probe selects past the LED bits
	localparam int SEL_OUT_READY  = 9;

	logic                  okClk;
	logic                  i_rst_n;
	accel_pkg::ctrl_word_t i_ctrl;
	logic                  i_pipe_in_write;
	logic [`WORD_W-1:0]    i_pipe_in_data;
	logic                  o_pipe_in_ready;
	logic                  i_pipe_out_read;
	logic [`WORD_W-1:0]    o_pipe_out_data;
	logic                  o_pipe_out_ready;
	logic [7:0]            o_led;

	integer             seed;
	int                 errors;
	int                 checks;
	int                 cycle_count = 0;
	logic [`WORD_W-1:0] exp_q [$];          // host order since the last fifo_rst

	accel_top UUT (
		.okClk            (okClk),
		.i_rst_n          (i_rst_n),
		.i_ctrl           (i_ctrl),
		.i_pipe_in_write  (i_pipe_in_write),
		.i_pipe_in_data   (i_pipe_in_data),
		.o_pipe_in_ready  (o_pipe_in_ready),
		.i_pipe_out_read  (i_pipe_out_read),
		.o_pipe_out_data  (o_pipe_out_data),
		.o_pipe_out_ready (o_pipe_out_ready),
		.o_led            (o_led)
	);

	initial begin
		okClk = 1'b0;
		forever #5 okClk = ~okClk;
	end

	always @(posedge okClk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("run stopped after %0d cycles without finishing", TIMEOUT_CYCLES);
			$display("Test failures found");
			$finish;
		end
	end

	// ------------------------------------------------------------
	// helpers
	// ------------------------------------------------------------
	// LED byte from bit 7 down with every LED active low
	function automatic logic [7:0] led_pattern(input logic in_full, input logic in_empty,
		input logic out_full, input logic out_empty, input logic wr_busy,
		input logic writes_en, input logic reads_en, input logic rd_busy);
		return ~{in_full, in_empty, out_full, out_empty, wr_busy, writes_en, reads_en, rd_busy};
	endfunction

	function automatic logic probe(input int sel);
		if (sel == SEL_IN_READY)
			return o_pipe_in_ready;
		else if (sel == SEL_OUT_READY)
			return o_pipe_out_ready;
		return o_led[sel];
	endfunction

	task automatic check_value(input string name, input logic [`WORD_W-1:0] got,
		input logic [`WORD_W-1:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("FAIL %s: got 0x%0h expected 0x%0h", name, got, exp);
		end
	endtask

	task automatic wait_for(input string name, input int sel, input logic level,
		input int max_cycles);
		int  n;
		bit  seen;
		seen = 1'b0;
		for (n = 0; n < max_cycles && !seen; n++) begin
			@(negedge okClk);                       // outputs settled
			seen = (probe(sel) == level);
		end
		checks++;
		assert (seen) else begin
			errors++;
			$display("%s did not reach %0d within %0d cycles", name, level, max_cycles);
		end
	endtask

	task automatic hold_level(input string name, input int sel, input logic level,
		input int cycles);
		int  n;
		bit  held;
		held = 1'b1;
		for (n = 0; n < cycles && held; n++) begin
			@(negedge okClk);
			held = (probe(sel) == level);
		end
		checks++;
		assert (held) else begin
			errors++;
			$display("%s left level %0d before %0d cycles passed", name, level, cycles);
		end
	endtask

	task automatic write_words(input int n, input bit keep);
		int                 i;
		logic [`WORD_W-1:0] word;
		for (i = 0; i < n; i++) begin
			word = $random(seed);
			@(posedge okClk);
			i_pipe_in_write <= 1'b1;
			i_pipe_in_data  <= word;
			if (keep)
				exp_q.push_back(word);
		end
		@(posedge okClk);
		i_pipe_in_write <= 1'b0;
	endtask

	task automatic pop_word();
		logic [`WORD_W-1:0] exp;
		wait_for("pipe-out word", LED_OUT_EMPTY, 1'b1, 100);
		exp = exp_q.pop_front();
		check_value("o_pipe_out_data", o_pipe_out_data, exp);
		@(posedge okClk);
		i_pipe_out_read <= 1'b1;                    // pops on the next edge
		@(posedge okClk);
		i_pipe_out_read <= 1'b0;
	endtask

	task automatic read_block();
		@(posedge okClk);                           // ready lags the count by one cycle
		wait_for("o_pipe_out_ready", SEL_OUT_READY, 1'b1, 300);
		repeat (`BLOCK_SIZE) pop_word();
	endtask

	task automatic set_enables(input logic writes_en, input logic reads_en);
		@(posedge okClk);
		i_ctrl.writes_en <= writes_en;
		i_ctrl.reads_en  <= reads_en;
	endtask

	task automatic pulse_fifo_rst();
		@(posedge okClk);
		i_ctrl.fifo_rst <= 1'b1;
		@(posedge okClk);
		i_ctrl.fifo_rst <= 1'b0;
		exp_q.delete();
	endtask

	// ------------------------------------------------------------
	// directed tests
	// ------------------------------------------------------------
	task automatic test_reset_state();
		wait_for("o_pipe_in_ready after reset", SEL_IN_READY, 1'b1, 3);
		check_value("o_pipe_out_ready", o_pipe_out_ready, 0);
		check_value("o_led", o_led, led_pattern(0, 1, 0, 1, 0, 0, 0, 0));
	endtask

	task automatic test_in_throttle();
		set_enables(1'b0, 1'b0);
		write_words(44, 1'b0);                      // exactly at the ready threshold
		hold_level("o_pipe_in_ready", SEL_IN_READY, 1'b1, 3);
		write_words(1, 1'b0);
		wait_for("o_pipe_in_ready fall", SEL_IN_READY, 1'b0, 2);
		pulse_fifo_rst();
		wait_for("o_pipe_in_ready after fifo_rst", SEL_IN_READY, 1'b1, 3);
		check_value("o_led[6]", o_led[LED_IN_EMPTY], 0);
	endtask

	task automatic test_partial_burst();
		set_enables(1'b1, 1'b0);
		write_words(5, 1'b1);                       // short of one burst
		hold_level("in_empty LED", LED_IN_EMPTY, 1'b1, 20);
		write_words(3, 1'b1);
		wait_for("wr_busy LED on", LED_WR_BUSY, 1'b0, 10);
		wait_for("in_empty LED", LED_IN_EMPTY, 1'b0, 40);
	endtask

	task automatic test_loopback();
		wait_for("o_pipe_in_ready", SEL_IN_READY, 1'b1, 4);
		write_words(`BLOCK_SIZE, 1'b1);
		wait_for("o_pipe_in_ready", SEL_IN_READY, 1'b1, 4);
		write_words(`BLOCK_SIZE, 1'b1);
		wait_for("in_empty LED", LED_IN_EMPTY, 1'b0, 100);
		wait_for("wr_busy LED", LED_WR_BUSY, 1'b1, 20);
		set_enables(1'b1, 1'b1);
		wait_for("rd_busy LED on", LED_RD_BUSY, 1'b0, 20);
		read_block();
		read_block();
		while (exp_q.size() > 0)
			pop_word();                             // the 8 left below one block
		@(negedge okClk);
		check_value("o_led[4]", o_led[LED_OUT_EMPTY], 0);
	endtask

	task automatic test_clear_output();
		wait_for("o_pipe_in_ready", SEL_IN_READY, 1'b1, 4);
		write_words(`BLOCK_SIZE, 1'b0);
		wait_for("o_pipe_out_ready", SEL_OUT_READY, 1'b1, 200);
		pulse_fifo_rst();
		wait_for("o_pipe_out_ready after fifo_rst", SEL_OUT_READY, 1'b0, 3);
		check_value("o_led", o_led, led_pattern(0, 1, 0, 1, 0, 1, 1, 0));
	endtask

	initial begin
		seed            = 79;
		errors          = 0;
		checks          = 0;
		i_rst_n         = 1'b0;
		i_ctrl          = '0;
		i_pipe_in_write = 1'b0;
		i_pipe_in_data  = '0;
		i_pipe_out_read = 1'b0;
		repeat (8) @(posedge okClk);
		i_rst_n <= 1'b1;

		test_reset_state();
		test_in_throttle();
		test_partial_burst();
		test_loopback();
		test_clear_output();

		repeat (4) @(posedge okClk);
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+hdl
hdl/accel_pkg.sv
hdl/sync_fifo.sv
hdl/host_pipes.sv
hdl/burst_dma.sv
hdl/blob_mem.sv
hdl/accel_top.sv
test/tb_accel_top.sv

// File: Makefile
VERILATOR  = verilator
FLAGS      = --binary --timing --assert -Wno-fatal -j 0
LINT_FLAGS = --lint-only --timing --assert
TOP        = tb_accel_top
FILELIST   = verilog.f
LOG        = sim.log
FAIL_MSG   = Test failures found

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation FAILED"; \
		exit 1; \
	else \
		echo "simulation passed"; \
	fi

clean:
	rm -rf obj_dir $(LOG)
